//--- replayQueuePkg.sv
/*
 * Replay queue shared constants
 * Queue depth, issue latency, spacing limit and lane field widths
 */
package replayQueuePkg;

    // Queue depth and the memory issue latency behind the stall threshold
    localparam int ENTRY_NUM = 16;
    localparam int MEM_LATENCY = 3;

    // Saturation point of the spacing stamp
    localparam int MAX_INTERVAL = 7;

    // Lane fields
    localparam int PTR_WIDTH = 5;
    localparam int PAYLOAD_WIDTH = 16;

    // Data cache miss handling
    localparam int MSHR_NUM = 4;
    localparam int SUBSET_WIDTH = 4;

endpackage

//--- replayQueuePointer.sv
/*
 * Replay queue pointers
 * Circular head and tail with an occupancy count and the stall threshold
 */
module replayQueuePointer import replayQueuePkg::*; #(
    parameter int entryNum = ENTRY_NUM
) (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            push,
    input  logic                            pop,
    output logic [$clog2(entryNum)-1:0]     headPtr,
    output logic [$clog2(entryNum)-1:0]     tailPtr,
    output logic [$clog2(entryNum+1)-1:0]   count,
    output logic                            full,
    output logic                            empty,
    output logic                            almostFull
);

    localparam int IDX_W = $clog2(entryNum);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(entryNum - 1);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tailPtr <= (tailPtr == LAST_IDX) ? '0 : tailPtr + 1'b1;
            end
            if (pop) begin
                headPtr <= (headPtr == LAST_IDX) ? '0 : headPtr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign full = (count == entryNum);
    assign empty = (count == 0);
    // Leaves room for the loads still in the memory pipe after a stall
    assign almostFull = (count >= entryNum - MEM_LATENCY);

endmodule

//--- replayQueueRam.sv
/*
 * Replay queue storage
 * Distributed dual-port RAM, synchronous write and asynchronous read
 */
module replayQueueRam #(
    parameter int entryNum = 16,
    parameter int entryWidth = 32
) (
    input  logic                            clk,
    input  logic                            we,
    input  logic [$clog2(entryNum)-1:0]     writeAddr,
    input  logic [entryWidth-1:0]           writeData,
    input  logic [$clog2(entryNum)-1:0]     readAddr,
    output logic [entryWidth-1:0]           readData
);

    logic [entryWidth-1:0] mem [entryNum];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[writeAddr] <= writeData;
        end
    end

    assign readData = mem[readAddr];

endmodule

//--- replayIntervalTimer.sv
/*
 * Replay spacing timer
 * Stamps each record with the cycles since the previous push and counts
 * the cycles since the previous pop, both saturating
 */
module replayIntervalTimer import replayQueuePkg::*; (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                push,
    input  logic                                pop,
    output logic [$clog2(MAX_INTERVAL+1)-1:0]   intervalIn,
    output logic [$clog2(MAX_INTERVAL+1)-1:0]   intervalCount
);

    localparam int STAMP_W = $clog2(MAX_INTERVAL + 1);
    localparam logic [STAMP_W-1:0] STAMP_MAX = STAMP_W'(MAX_INTERVAL);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            intervalIn <= '0;
            intervalCount <= '0;
        end else begin
            if (push) begin
                intervalIn <= '0;
            end else if (intervalIn < STAMP_MAX) begin
                intervalIn <= intervalIn + 1'b1;
            end

            // Mirrors the push side so pops keep the recorded spacing
            if (pop) begin
                intervalCount <= '0;
            end else if (intervalCount < STAMP_MAX) begin
                intervalCount <= intervalCount + 1'b1;
            end
        end
    end

endmodule

//--- replayPopControl.sv
/*
 * Replay queue push and pop decisions
 * Push on any valid lane, pop once the spacing has elapsed and no head
 * load is still waiting for its MSHR data
 */
module replayPopControl import replayQueuePkg::*; #(
    parameter int intWidth = 1,
    parameter int memWidth = 1
) (
    input  logic [intWidth-1:0]                             intRecordValid,
    input  logic [memWidth-1:0]                             memRecordValid,
    input  logic                                            full,
    input  logic                                            empty,
    input  logic [$clog2(MAX_INTERVAL+1)-1:0]               intervalCount,
    input  logic [$clog2(MAX_INTERVAL+1)-1:0]               headStamp,
    input  logic [memWidth-1:0]                             headMemValid,
    input  logic [memWidth-1:0]                             headIsLoad,
    input  logic [memWidth-1:0]                             headHasMshr,
    input  logic [memWidth-1:0][$clog2(MSHR_NUM)-1:0]       headMshrId,
    input  logic [memWidth-1:0]                             headAddrHit,
    input  logic [memWidth-1:0][SUBSET_WIDTH-1:0]           headAddrSubset,
    input  logic [MSHR_NUM-1:0]                             mshrValid,
    input  logic [MSHR_NUM-1:0]                             mshrReady,
    input  logic [MSHR_NUM-1:0][SUBSET_WIDTH-1:0]           mshrAddrSubset,
    output logic                                            push,
    output logic                                            pop
);

    logic [memWidth-1:0] loadBlocked;
    logic [memWidth-1:0] subsetMatch;

    // Records offered while full are dropped, upstream watches stallUpper
    assign push = (|intRecordValid || |memRecordValid) && !full;

    always_comb begin
        for (int i = 0; i < memWidth; i++) begin
            // The MSHR still serves the line this load hit on
            subsetMatch[i] = mshrValid[headMshrId[i]] &&
                (mshrAddrSubset[headMshrId[i]] == headAddrSubset[i]);

            loadBlocked[i] = headMemValid[i] && headIsLoad[i] &&
                !mshrReady[headMshrId[i]] &&
                (headHasMshr[i] || (headAddrHit[i] && subsetMatch[i]));
        end
    end

    assign pop = !empty && (intervalCount >= headStamp) && !(|loadBlocked);

endmodule

//--- replayFlushFilter.sv
/*
 * Replay output stage with selective flush
 * Registers the popped entry, masks lanes inside a recovered range and
 * releases the MSHRs held by flushed loads
 */
module replayFlushFilter import replayQueuePkg::*; #(
    parameter int intWidth = 1,
    parameter int memWidth = 1,
    parameter int entryNum = ENTRY_NUM,
    // Packed entry layout, shared with the top level
    localparam int MSHR_ID_W = $clog2(MSHR_NUM),
    localparam int STAMP_W = $clog2(MAX_INTERVAL + 1),
    localparam int INT_LANE_W = 1 + PTR_WIDTH + PAYLOAD_WIDTH,
    localparam int MEM_LANE_W = INT_LANE_W + 3 + MSHR_ID_W + SUBSET_WIDTH,
    localparam int MEM_BASE = intWidth * INT_LANE_W,
    localparam int ENTRY_W = MEM_BASE + memWidth * MEM_LANE_W + STAMP_W
) (
    input  logic                                        clk,
    input  logic                                        rstN,
    input  logic                                        pop,
    input  logic [ENTRY_W-1:0]                          headEntry,
    input  logic                                        recoveryStart,
    input  logic [PTR_WIDTH-1:0]                        flushRangeHead,
    input  logic [PTR_WIDTH-1:0]                        flushRangeTail,
    input  logic                                        flushAll,
    input  logic [$clog2(entryNum+1)-1:0]               count,
    output logic [intWidth-1:0]                         intReplayValid,
    output logic [intWidth-1:0][PTR_WIDTH-1:0]          intReplayPtr,
    output logic [intWidth-1:0][PAYLOAD_WIDTH-1:0]      intReplayPayload,
    output logic [memWidth-1:0]                         memReplayValid,
    output logic [memWidth-1:0][PTR_WIDTH-1:0]          memReplayPtr,
    output logic [memWidth-1:0][PAYLOAD_WIDTH-1:0]      memReplayPayload,
    output logic                                        replay,
    output logic                                        flushedOpExist,
    output logic [MSHR_NUM-1:0]                         mshrRelease
);

    localparam int VALID_POS = PAYLOAD_WIDTH + PTR_WIDTH;

    logic [ENTRY_W-1:0] entryReg;
    logic [intWidth-1:0] intValidReg;
    logic [memWidth-1:0] memValidReg;
    logic [$clog2(entryNum+1)-1:0] flushCount;
    logic [PTR_WIDTH-1:0] rangeHead;
    logic [PTR_WIDTH-1:0] rangeTail;
    logic flushAllReg;
    logic [intWidth-1:0] flushInt;
    logic [memWidth-1:0] flushMem;

    // Active-list distance test, wraps modulo the pointer width
    function automatic logic inRange(
        input logic [PTR_WIDTH-1:0] ptr,
        input logic [PTR_WIDTH-1:0] head,
        input logic [PTR_WIDTH-1:0] tail
    );
        logic [PTR_WIDTH-1:0] offset;
        logic [PTR_WIDTH-1:0] span;
        offset = ptr - head;
        span = tail - head;
        return offset < span;
    endfunction

    always_ff @(posedge clk) begin
        if (pop) begin
            entryReg <= headEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            intValidReg <= '0;
            memValidReg <= '0;
            replay <= 1'b0;
        end else begin
            for (int i = 0; i < intWidth; i++) begin
                intValidReg[i] <= pop && headEntry[i*INT_LANE_W + VALID_POS];
            end
            for (int i = 0; i < memWidth; i++) begin
                memValidReg[i] <= pop && headEntry[MEM_BASE + i*MEM_LANE_W + VALID_POS];
            end
            // Every stored entry holds at least one valid lane
            replay <= pop;
        end
    end

    // Entries queued at recovery time may hold flushed operations
    always_ff @(posedge clk) begin
        if (!rstN) begin
            flushCount <= '0;
        end else if (recoveryStart) begin
            flushCount <= count;
        end else if (flushCount != 0 && replay) begin
            flushCount <= flushCount - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (recoveryStart) begin
            rangeHead <= flushRangeHead;
            rangeTail <= flushRangeTail;
            flushAllReg <= flushAll;
        end
    end

    assign flushedOpExist = (flushCount != 0);

    always_comb begin
        for (int i = 0; i < intWidth; i++) begin
            intReplayPayload[i] = entryReg[i*INT_LANE_W +: PAYLOAD_WIDTH];
            intReplayPtr[i] = entryReg[i*INT_LANE_W + PAYLOAD_WIDTH +: PTR_WIDTH];
            flushInt[i] = flushedOpExist &&
                (flushAllReg || inRange(intReplayPtr[i], rangeHead, rangeTail));
            intReplayValid[i] = intValidReg[i] && !flushInt[i];
        end

        mshrRelease = '0;
        for (int i = 0; i < memWidth; i++) begin
            memReplayPayload[i] = entryReg[MEM_BASE + i*MEM_LANE_W +: PAYLOAD_WIDTH];
            memReplayPtr[i] = entryReg[MEM_BASE + i*MEM_LANE_W + PAYLOAD_WIDTH +: PTR_WIDTH];
            flushMem[i] = flushedOpExist &&
                (flushAllReg || inRange(memReplayPtr[i], rangeHead, rangeTail));
            memReplayValid[i] = memValidReg[i] && !flushMem[i];

            // A flushed load gives back the MSHR it allocated
            if (memValidReg[i] && flushMem[i] &&
                entryReg[MEM_BASE + i*MEM_LANE_W + INT_LANE_W + 1]) begin
                mshrRelease[entryReg[MEM_BASE + i*MEM_LANE_W + INT_LANE_W + 3 +: MSHR_ID_W]]
                    = 1'b1;
            end
        end
    end

endmodule

//--- replayQueue.sv
/*
 * Replay queue
 * Records issued operations that missed their operands and replays them
 * in order with the recorded spacing, holding loads on pending MSHRs
 */
module replayQueue import replayQueuePkg::*; #(
    parameter int intWidth = 1,
    parameter int memWidth = 1,
    parameter int entryNum = ENTRY_NUM
) (
    input  logic                                        clk,
    input  logic                                        rstN,
    input  logic [intWidth-1:0]                         intRecordValid,
    input  logic [intWidth-1:0][PTR_WIDTH-1:0]          intRecordPtr,
    input  logic [intWidth-1:0][PAYLOAD_WIDTH-1:0]      intRecordPayload,
    input  logic [memWidth-1:0]                         memRecordValid,
    input  logic [memWidth-1:0][PTR_WIDTH-1:0]          memRecordPtr,
    input  logic [memWidth-1:0][PAYLOAD_WIDTH-1:0]      memRecordPayload,
    input  logic [memWidth-1:0]                         memRecordIsLoad,
    input  logic [memWidth-1:0]                         memRecordHasMshr,
    input  logic [memWidth-1:0][$clog2(MSHR_NUM)-1:0]   memRecordMshrId,
    input  logic [memWidth-1:0]                         memRecordAddrHit,
    input  logic [memWidth-1:0][SUBSET_WIDTH-1:0]       memRecordAddrSubset,
    input  logic [MSHR_NUM-1:0]                         mshrValid,
    input  logic [MSHR_NUM-1:0]                         mshrReady,
    input  logic [MSHR_NUM-1:0][SUBSET_WIDTH-1:0]       mshrAddrSubset,
    input  logic                                        recoveryStart,
    input  logic [PTR_WIDTH-1:0]                        flushRangeHead,
    input  logic [PTR_WIDTH-1:0]                        flushRangeTail,
    input  logic                                        flushAll,
    output logic [intWidth-1:0]                         intReplayValid,
    output logic [intWidth-1:0][PTR_WIDTH-1:0]          intReplayPtr,
    output logic [intWidth-1:0][PAYLOAD_WIDTH-1:0]      intReplayPayload,
    output logic [memWidth-1:0]                         memReplayValid,
    output logic [memWidth-1:0][PTR_WIDTH-1:0]          memReplayPtr,
    output logic [memWidth-1:0][PAYLOAD_WIDTH-1:0]      memReplayPayload,
    output logic                                        replay,
    output logic                                        stallUpper,
    output logic                                        flushedOpExist,
    output logic [MSHR_NUM-1:0]                         mshrRelease
);

    // Lane layout from bit 0: payload, pointer, valid, then the memory extras
    localparam int MSHR_ID_W = $clog2(MSHR_NUM);
    localparam int STAMP_W = $clog2(MAX_INTERVAL + 1);
    localparam int INT_LANE_W = 1 + PTR_WIDTH + PAYLOAD_WIDTH;
    localparam int MEM_LANE_W = INT_LANE_W + 3 + MSHR_ID_W + SUBSET_WIDTH;
    localparam int MEM_BASE = intWidth * INT_LANE_W;
    localparam int ENTRY_W = MEM_BASE + memWidth * MEM_LANE_W + STAMP_W;
    localparam int IDX_W = $clog2(entryNum);

    logic push;
    logic pop;
    logic [IDX_W-1:0] headPtr;
    logic [IDX_W-1:0] tailPtr;
    logic [$clog2(entryNum+1)-1:0] count;
    logic full;
    logic empty;
    logic almostFull;
    logic [STAMP_W-1:0] intervalIn;
    logic [STAMP_W-1:0] intervalCount;
    logic [ENTRY_W-1:0] recordEntry;
    logic [ENTRY_W-1:0] headEntry;

    logic [STAMP_W-1:0] headStamp;
    logic [memWidth-1:0] headMemValid;
    logic [memWidth-1:0] headIsLoad;
    logic [memWidth-1:0] headHasMshr;
    logic [memWidth-1:0][MSHR_ID_W-1:0] headMshrId;
    logic [memWidth-1:0] headAddrHit;
    logic [memWidth-1:0][SUBSET_WIDTH-1:0] headAddrSubset;

    always_comb begin
        for (int i = 0; i < intWidth; i++) begin
            recordEntry[i*INT_LANE_W +: INT_LANE_W] =
                {intRecordValid[i], intRecordPtr[i], intRecordPayload[i]};
        end
        for (int i = 0; i < memWidth; i++) begin
            recordEntry[MEM_BASE + i*MEM_LANE_W +: MEM_LANE_W] =
                {memRecordAddrSubset[i], memRecordMshrId[i], memRecordAddrHit[i],
                 memRecordHasMshr[i], memRecordIsLoad[i],
                 memRecordValid[i], memRecordPtr[i], memRecordPayload[i]};
        end
        recordEntry[ENTRY_W-1 -: STAMP_W] = intervalIn;
    end

    // Head fields needed by the pop decision
    always_comb begin
        logic [MEM_LANE_W-1:0] lane;
        headStamp = headEntry[ENTRY_W-1 -: STAMP_W];
        for (int i = 0; i < memWidth; i++) begin
            lane = headEntry[MEM_BASE + i*MEM_LANE_W +: MEM_LANE_W];
            headMemValid[i] = lane[PAYLOAD_WIDTH + PTR_WIDTH];
            headIsLoad[i] = lane[INT_LANE_W];
            headHasMshr[i] = lane[INT_LANE_W + 1];
            headAddrHit[i] = lane[INT_LANE_W + 2];
            headMshrId[i] = lane[INT_LANE_W + 3 +: MSHR_ID_W];
            headAddrSubset[i] = lane[INT_LANE_W + 3 + MSHR_ID_W +: SUBSET_WIDTH];
        end
    end

    replayPopControl #(
        .intWidth(intWidth),
        .memWidth(memWidth)
    ) popControl_i (
        .intRecordValid(intRecordValid),
        .memRecordValid(memRecordValid),
        .full(full),
        .empty(empty),
        .intervalCount(intervalCount),
        .headStamp(headStamp),
        .headMemValid(headMemValid),
        .headIsLoad(headIsLoad),
        .headHasMshr(headHasMshr),
        .headMshrId(headMshrId),
        .headAddrHit(headAddrHit),
        .headAddrSubset(headAddrSubset),
        .mshrValid(mshrValid),
        .mshrReady(mshrReady),
        .mshrAddrSubset(mshrAddrSubset),
        .push(push),
        .pop(pop)
    );

    replayQueuePointer #(.entryNum(entryNum)) pointer_i (
        .clk(clk),
        .rstN(rstN),
        .push(push),
        .pop(pop),
        .headPtr(headPtr),
        .tailPtr(tailPtr),
        .count(count),
        .full(full),
        .empty(empty),
        .almostFull(almostFull)
    );

    replayQueueRam #(
        .entryNum(entryNum),
        .entryWidth(ENTRY_W)
    ) ram_i (
        .clk(clk),
        .we(push),
        .writeAddr(tailPtr),
        .writeData(recordEntry),
        .readAddr(headPtr),
        .readData(headEntry)
    );

    replayIntervalTimer timer_i (
        .clk(clk),
        .rstN(rstN),
        .push(push),
        .pop(pop),
        .intervalIn(intervalIn),
        .intervalCount(intervalCount)
    );

    replayFlushFilter #(
        .intWidth(intWidth),
        .memWidth(memWidth),
        .entryNum(entryNum)
    ) flushFilter_i (
        .clk(clk),
        .rstN(rstN),
        .pop(pop),
        .headEntry(headEntry),
        .recoveryStart(recoveryStart),
        .flushRangeHead(flushRangeHead),
        .flushRangeTail(flushRangeTail),
        .flushAll(flushAll),
        .count(count),
        .intReplayValid(intReplayValid),
        .intReplayPtr(intReplayPtr),
        .intReplayPayload(intReplayPayload),
        .memReplayValid(memReplayValid),
        .memReplayPtr(memReplayPtr),
        .memReplayPayload(memReplayPayload),
        .replay(replay),
        .flushedOpExist(flushedOpExist),
        .mshrRelease(mshrRelease)
    );

    // Upper stages hold while replaying or when the queue nears full
    assign stallUpper = replay || almostFull;

endmodule

//--- replayQueueTb.sv
/*
 * Replay queue testbench
 * Runs records, MSHR updates and recoveries from the vector file and
 * checks every replayed record, its spacing and the stall and flush flags
 */
module replayQueueTb import replayQueuePkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MSHR_ID_W = $clog2(MSHR_NUM);
    localparam int CAP_W = 2 + MSHR_NUM + 2 * (1 + PTR_WIDTH + PAYLOAD_WIDTH);

    logic clk = 1'b0;
    logic rstN;
    logic intRecordValid;
    logic [PTR_WIDTH-1:0] intRecordPtr;
    logic [PAYLOAD_WIDTH-1:0] intRecordPayload;
    logic memRecordValid;
    logic [PTR_WIDTH-1:0] memRecordPtr;
    logic [PAYLOAD_WIDTH-1:0] memRecordPayload;
    logic memRecordIsLoad;
    logic memRecordHasMshr;
    logic [MSHR_ID_W-1:0] memRecordMshrId;
    logic memRecordAddrHit;
    logic [SUBSET_WIDTH-1:0] memRecordAddrSubset;
    logic [MSHR_NUM-1:0] mshrValid;
    logic [MSHR_NUM-1:0] mshrReady;
    logic [MSHR_NUM-1:0][SUBSET_WIDTH-1:0] mshrAddrSubset;
    logic recoveryStart;
    logic [PTR_WIDTH-1:0] flushRangeHead;
    logic [PTR_WIDTH-1:0] flushRangeTail;
    logic flushAll;
    logic intReplayValid;
    logic [PTR_WIDTH-1:0] intReplayPtr;
    logic [PAYLOAD_WIDTH-1:0] intReplayPayload;
    logic memReplayValid;
    logic [PTR_WIDTH-1:0] memReplayPtr;
    logic [PAYLOAD_WIDTH-1:0] memReplayPayload;
    logic replay;
    logic stallUpper;
    logic flushedOpExist;
    logic [MSHR_NUM-1:0] mshrRelease;

    // Replays seen by the monitor and the cycle of each
    logic [CAP_W-1:0] capQ[$];
    int cycQ[$];
    int cycle = 0;

    always #10 clk = ~clk;

    replayQueue #(.intWidth(1), .memWidth(1), .entryNum(ENTRY_NUM)) replayQueue_i (.*);

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkIntLane(input logic v, input logic [PTR_WIDTH-1:0] p,
                                input logic [PAYLOAD_WIDTH-1:0] d, input logic ev,
                                input logic [PTR_WIDTH-1:0] ep,
                                input logic [PAYLOAD_WIDTH-1:0] ed, input int cyc);
        if (v !== ev || (ev && (p !== ep || d !== ed))) begin
            failRun($sformatf(
                "mismatch at %0t: int lane in cycle %0d got %b/%h/%h, expected %b/%h/%h",
                $time, cyc, v, p, d, ev, ep, ed));
        end
    endtask

    task automatic checkMemLane(input logic v, input logic [PTR_WIDTH-1:0] p,
                                input logic [PAYLOAD_WIDTH-1:0] d, input logic ev,
                                input logic [PTR_WIDTH-1:0] ep,
                                input logic [PAYLOAD_WIDTH-1:0] ed, input int cyc);
        if (v !== ev || (ev && (p !== ep || d !== ed))) begin
            failRun($sformatf(
                "mismatch at %0t: mem lane in cycle %0d got %b/%h/%h, expected %b/%h/%h",
                $time, cyc, v, p, d, ev, ep, ed));
        end
    endtask

    task automatic checkFlags(input logic r, input logic s, input logic f,
                              input logic er, input logic es, input logic ef);
        if ({r, s, f} !== {er, es, ef}) begin
            failRun($sformatf("mismatch at %0t: replay/stall/flushed got %b%b%b, expected %b%b%b",
                $time, r, s, f, er, es, ef));
        end
    endtask

    task automatic checkRelease(input logic [MSHR_NUM-1:0] got,
                                input logic [MSHR_NUM-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch at %0t: mshrRelease got %b, expected %b",
                $time, got, exp));
        end
    endtask

    // Registered outputs still hold this cycle's values at the edge
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (rstN && replay) begin
            capQ.push_back({stallUpper, flushedOpExist, mshrRelease, memReplayValid,
                memReplayPtr, memReplayPayload, intReplayValid, intReplayPtr,
                intReplayPayload});
            cycQ.push_back(cycle);
        end else if (rstN && (intReplayValid || memReplayValid || mshrRelease != 0)) begin
            failRun($sformatf("mismatch at %0t: lane valid or release without replay", $time));
        end
    end

    initial begin
        int fd;
        int n;
        int waited;
        int cyc;
        int lastCycle;
        int unsigned v[11];
        string cmd;
        string rest;
        logic gs;
        logic gf;
        logic gmv;
        logic giv;
        logic [MSHR_NUM-1:0] grel;
        logic [PTR_WIDTH-1:0] gmp;
        logic [PTR_WIDTH-1:0] gip;
        logic [PAYLOAD_WIDTH-1:0] gmd;
        logic [PAYLOAD_WIDTH-1:0] gid;

        lastCycle = -1;
        rstN = 1'b0;
        intRecordValid = 1'b0;
        intRecordPtr = '0;
        intRecordPayload = '0;
        memRecordValid = 1'b0;
        memRecordPtr = '0;
        memRecordPayload = '0;
        memRecordIsLoad = 1'b0;
        memRecordHasMshr = 1'b0;
        memRecordMshrId = '0;
        memRecordAddrHit = 1'b0;
        memRecordAddrSubset = '0;
        mshrValid = '0;
        mshrReady = '0;
        mshrAddrSubset = '0;
        recoveryStart = 1'b0;
        flushRangeHead = '0;
        flushRangeTail = '0;
        flushAll = 1'b0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;

        fd = $fopen("replayQueueVectors.txt", "r");
        if (fd == 0) failRun("could not open the vector file");

        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd[0] == "#") begin
                n = $fgets(rest, fd);
            end else if (cmd == "R") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
                    v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
                if (n != 11) failRun("malformed record line in the vector file");
                intRecordValid = v[0][0];
                intRecordPtr = PTR_WIDTH'(v[1]);
                intRecordPayload = PAYLOAD_WIDTH'(v[2]);
                memRecordValid = v[3][0];
                memRecordPtr = PTR_WIDTH'(v[4]);
                memRecordPayload = PAYLOAD_WIDTH'(v[5]);
                memRecordIsLoad = v[6][0];
                memRecordHasMshr = v[7][0];
                memRecordMshrId = MSHR_ID_W'(v[8]);
                memRecordAddrHit = v[9][0];
                memRecordAddrSubset = SUBSET_WIDTH'(v[10]);
                @(negedge clk);
                intRecordValid = 1'b0;
                memRecordValid = 1'b0;
            end else if (cmd == "I") begin
                n = $fscanf(fd, "%h", v[0]);
                repeat (v[0]) @(negedge clk);
            end else if (cmd == "M") begin
                n = $fscanf(fd, "%h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5]);
                if (n != 6) failRun("malformed MSHR line in the vector file");
                mshrValid = MSHR_NUM'(v[0]);
                mshrReady = MSHR_NUM'(v[1]);
                for (int i = 0; i < MSHR_NUM; i++) begin
                    mshrAddrSubset[i] = SUBSET_WIDTH'(v[2 + i]);
                end
            end else if (cmd == "F") begin
                n = $fscanf(fd, "%h %h %h", v[0], v[1], v[2]);
                flushRangeHead = PTR_WIDTH'(v[0]);
                flushRangeTail = PTR_WIDTH'(v[1]);
                flushAll = v[2][0];
                recoveryStart = 1'b1;
                @(negedge clk);
                recoveryStart = 1'b0;
            end else if (cmd == "S") begin
                n = $fscanf(fd, "%h %h %h", v[0], v[1], v[2]);
                checkFlags(replay, stallUpper, flushedOpExist, v[0][0], v[1][0], v[2][0]);
            end else if (cmd == "N") begin
                if (capQ.size() != 0) begin
                    failRun($sformatf("mismatch at %0t: a held load was replayed", $time));
                end
            end else if (cmd == "E") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2], v[3],
                    v[4], v[5], v[6], v[7], v[8], v[9]);
                if (n != 10) failRun("malformed expect line in the vector file");
                waited = 0;
                while (capQ.size() == 0) begin
                    if (waited >= int'(v[0])) failRun("no replay arrived before the timeout");
                    @(negedge clk);
                    waited++;
                end
                {gs, gf, grel, gmv, gmp, gmd, giv, gip, gid} = capQ.pop_front();
                cyc = cycQ.pop_front();
                if (v[1] != 0 && cyc - lastCycle != int'(v[1])) begin
                    failRun($sformatf("mismatch at %0t: replay gap %0d, expected %0d",
                        $time, cyc - lastCycle, v[1]));
                end
                lastCycle = cyc;
                checkIntLane(giv, gip, gid, v[2][0], PTR_WIDTH'(v[3]),
                    PAYLOAD_WIDTH'(v[4]), cyc);
                checkMemLane(gmv, gmp, gmd, v[5][0], PTR_WIDTH'(v[6]),
                    PAYLOAD_WIDTH'(v[7]), cyc);
                checkRelease(grel, MSHR_NUM'(v[8]));
                checkFlags(1'b1, gs, gf, 1'b1, 1'b1, v[9][0]);
            end else begin
                failRun("unknown command in the vector file");
            end
        end
        $fclose(fd);

        if (capQ.size() != 0) begin
            failRun("replays arrived that the vector file does not expect");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- sources.f
replayQueuePkg.sv
replayQueuePointer.sv
replayQueueRam.sv
replayIntervalTimer.sv
replayPopControl.sv
replayFlushFilter.sv
replayQueue.sv
replayQueueTb.sv

//--- Makefile
TOP = replayQueueTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module replayQueue

sim:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP) -o simv
	./obj_dir/simv

clean:
	rm -rf obj_dir

//--- replayQueueVectors.txt
# R intV intPtr intPay memV memPtr memPay isLoad hasMshr mshrId addrHit subset
# E waitLimit gap intV intPtr intPay memV memPtr memPay release flushed
# I cycles, M valid ready sub0 sub1 sub2 sub3, F head tail all, S replay stall flushed, N
S 0 0 0
M 0 0 0 0 0 0
I 8
R 1 01 1111 0 00 0000 0 0 0 0 0
R 1 02 2222 0 00 0000 0 0 0 0 0
I 2
R 0 00 0000 1 03 3333 0 0 0 0 0
I 6
R 1 04 4444 1 05 5555 0 0 0 0 0
E C8 0 1 01 1111 0 00 0000 0 0
E C8 1 1 02 2222 0 00 0000 0 0
E C8 3 0 00 0000 1 03 3333 0 0
E C8 7 1 04 4444 1 05 5555 0 0
# Load holding MSHR 2 waits for its data
M 4 0 0 0 0 0
R 0 00 0000 1 06 6666 1 1 2 0 0
I A
N
M 4 4 0 0 0 0
E C8 0 0 00 0000 1 06 6666 0 0
# Hit load whose MSHR now serves another subset goes straight through
M 2 0 0 6 0 0
I 8
R 0 00 0000 1 07 7777 1 0 1 1 5
I 3
E 0 0 0 00 0000 1 07 7777 0 0
# Matching subset holds the load
R 0 00 0000 1 08 8888 1 0 1 1 6
I A
N
M 2 2 0 6 0 0
E C8 0 0 00 0000 1 08 8888 0 0
# Fill to the stall threshold behind a blocked load, then recover
I 8
M 1 0 0 0 0 0
R 0 00 0000 1 05 5A5A 1 1 0 0 0
R 1 01 A001 0 00 0000 0 0 0 0 0
R 1 02 A002 0 00 0000 0 0 0 0 0
R 1 03 A003 0 00 0000 0 0 0 0 0
R 1 04 A004 0 00 0000 0 0 0 0 0
R 1 05 A005 0 00 0000 0 0 0 0 0
R 1 06 A006 0 00 0000 0 0 0 0 0
R 1 07 A007 0 00 0000 0 0 0 0 0
R 1 08 A008 0 00 0000 0 0 0 0 0
R 1 09 A009 0 00 0000 0 0 0 0 0
R 1 0A A00A 0 00 0000 0 0 0 0 0
R 1 0B A00B 0 00 0000 0 0 0 0 0
S 0 0 0
R 1 0C A00C 0 00 0000 0 0 0 0 0
S 0 1 0
F 04 08 0
S 0 1 1
M 1 1 0 0 0 0
E C8 0 0 00 0000 0 00 0000 1 1
E C8 1 1 01 A001 0 00 0000 0 1
E C8 1 1 02 A002 0 00 0000 0 1
E C8 1 1 03 A003 0 00 0000 0 1
E C8 1 0 00 0000 0 00 0000 0 1
E C8 1 0 00 0000 0 00 0000 0 1
E C8 1 0 00 0000 0 00 0000 0 1
E C8 1 0 00 0000 0 00 0000 0 1
E C8 1 1 08 A008 0 00 0000 0 1
E C8 1 1 09 A009 0 00 0000 0 1
E C8 1 1 0A A00A 0 00 0000 0 1
E C8 1 1 0B A00B 0 00 0000 0 1
E C8 1 1 0C A00C 0 00 0000 0 1
I 2
S 0 0 0
